// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

  // widths
  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int ALU_W      = 10;
  localparam int BJ_W       = 8;

  typedef logic [XLEN-1:0]       reg_t;
  typedef logic [ILEN-1:0]       inst_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [ALU_W-1:0]      alu_op_t;
  typedef logic [BJ_W-1:0]       bj_t;

  // one-hot alu selector, bit positions
  localparam int ALU_ADD  = 0;
  localparam int ALU_SUB  = 1;
  localparam int ALU_SLT  = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_XOR  = 4;
  localparam int ALU_OR   = 5;
  localparam int ALU_AND  = 6;
  localparam int ALU_SLL  = 7;
  localparam int ALU_SRL  = 8;
  localparam int ALU_SRA  = 9;

  // one-hot branch/jump selector, bit positions
  localparam int BJ_BEQ  = 0;
  localparam int BJ_BNE  = 1;
  localparam int BJ_BLT  = 2;
  localparam int BJ_BGE  = 3;
  localparam int BJ_BLTU = 4;
  localparam int BJ_BGEU = 5;
  localparam int BJ_JALR = 6;
  localparam int BJ_JAL  = 7;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_LOAD      = 7'h03;
  localparam logic [6:0] OPC_FENCE     = 7'h0f;
  localparam logic [6:0] OPC_OP_IMM    = 7'h13;
  localparam logic [6:0] OPC_AUIPC     = 7'h17;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'h1b;
  localparam logic [6:0] OPC_STORE     = 7'h23;
  localparam logic [6:0] OPC_OP        = 7'h33;
  localparam logic [6:0] OPC_LUI       = 7'h37;
  localparam logic [6:0] OPC_OP_32     = 7'h3b;
  localparam logic [6:0] OPC_BRANCH    = 7'h63;
  localparam logic [6:0] OPC_JALR      = 7'h67;
  localparam logic [6:0] OPC_JAL       = 7'h6f;
  localparam logic [6:0] OPC_SYSTEM    = 7'h73;

endpackage

// File: hdl/core_pkg.sv
package core_pkg;

  // instruction queue, one credit per entry
  localparam int IQ_DEPTH = 4;
  localparam int IQ_PTR_W = $clog2(IQ_DEPTH);

  // pointers wrap on their own, depth is a power of two
  typedef logic [IQ_PTR_W-1:0] iq_ptr_t;

  // one extra bit so a full queue can be counted
  typedef logic [IQ_PTR_W:0]   iq_count_t;

endpackage

// File: hdl/inst_queue.sv
`timescale 1ns/100ps

module inst_queue (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  rv_isa_pkg::inst_t   in_inst,
  input  rv_isa_pkg::reg_t    in_pc,
  input  logic                q_pop,
  output logic                q_valid,
  output rv_isa_pkg::inst_t   q_inst,
  output rv_isa_pkg::reg_t    q_pc,
  output logic                in_credit
);

  rv_isa_pkg::inst_t   inst_mem [core_pkg::IQ_DEPTH];
  rv_isa_pkg::reg_t    pc_mem   [core_pkg::IQ_DEPTH];

  core_pkg::iq_ptr_t   wr_ptr;
  core_pkg::iq_ptr_t   rd_ptr;
  core_pkg::iq_count_t count;
  logic                pop;

  assign q_valid = (count != '0);

  // only pop what is actually there
  assign pop = q_pop & q_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + core_pkg::iq_count_t'(in_valid) - core_pkg::iq_count_t'(pop);
      // freed entry goes back to the sender one cycle later
      in_credit <= pop;
    end
  end

  // storage, no overflow check since the sender is credit bound
  always_ff @(posedge clk) begin
    if (in_valid) begin
      inst_mem[wr_ptr] <= in_inst;
      pc_mem[wr_ptr]   <= in_pc;
    end
  end

  // head entry
  assign q_inst = inst_mem[rd_ptr];
  assign q_pc   = pc_mem[rd_ptr];

endmodule

// File: hdl/id_stage.sv
`timescale 1ns/100ps

module id_stage (
  input  rv_isa_pkg::inst_t     inst,
  input  rv_isa_pkg::reg_t      pc,
  input  rv_isa_pkg::reg_t      r_data1,
  output rv_isa_pkg::reg_addr_t rs1_addr,
  output rv_isa_pkg::reg_addr_t rs2_addr,
  output logic                  rd_w_ena,
  output rv_isa_pkg::reg_addr_t rd_w_addr,
  output rv_isa_pkg::alu_op_t   alu_op,
  output rv_isa_pkg::bj_t       bj_op,
  output logic                  is_word_op,
  output logic                  op1_sel_pc,
  output logic                  op2_sel_imm,
  output rv_isa_pkg::reg_t      imm,
  output rv_isa_pkg::reg_t      jmp_off,
  output logic                  unsupported
);

  localparam int XLEN = rv_isa_pkg::XLEN;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [7:0] f3_hot;
  logic       f7_zero;
  logic       f7_alt;

  rv_isa_pkg::reg_t imm_i, imm_s, imm_b, imm_u, imm_j;
  rv_isa_pkg::reg_t jalr_sum, jalr_off;

  logic is_load, is_fence, is_op_imm, is_auipc, is_op_imm_32, is_store;
  logic is_op, is_lui, is_op_32, is_branch, is_jalr, is_jal, is_system;
  logic op_imm_ok, op_imm32_ok, op_ok, op32_ok, br_ok, jalr_ok;
  logic imm_ok, reg_ok, alu_ok;
  logic rs1_ena, rs2_ena;

  // instruction fields
  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign funct7  = inst[31:25];
  assign f3_hot  = 8'b1 << funct3;
  assign f7_zero = (funct7 == 7'h00);
  assign f7_alt  = (funct7 == 7'h20);

  // sign-extended immediates
  assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // opcode classes
  assign is_load      = (opcode == rv_isa_pkg::OPC_LOAD);
  assign is_fence     = (opcode == rv_isa_pkg::OPC_FENCE);
  assign is_op_imm    = (opcode == rv_isa_pkg::OPC_OP_IMM);
  assign is_auipc     = (opcode == rv_isa_pkg::OPC_AUIPC);
  assign is_op_imm_32 = (opcode == rv_isa_pkg::OPC_OP_IMM_32);
  assign is_store     = (opcode == rv_isa_pkg::OPC_STORE);
  assign is_op        = (opcode == rv_isa_pkg::OPC_OP);
  assign is_lui       = (opcode == rv_isa_pkg::OPC_LUI);
  assign is_op_32     = (opcode == rv_isa_pkg::OPC_OP_32);
  assign is_branch    = (opcode == rv_isa_pkg::OPC_BRANCH);
  assign is_jalr      = (opcode == rv_isa_pkg::OPC_JALR);
  assign is_jal       = (opcode == rv_isa_pkg::OPC_JAL);
  assign is_system    = (opcode == rv_isa_pkg::OPC_SYSTEM);

  // legal funct combinations, rv64 shifts take a 6-bit shamt
  assign op_imm_ok = is_op_imm & (~(f3_hot[1] | f3_hot[5])
                   | f3_hot[1] & (inst[31:26] == 6'h00)
                   | f3_hot[5] & ((inst[31:26] == 6'h00) | (inst[31:26] == 6'h10)));
  assign op_imm32_ok = is_op_imm_32 & (f3_hot[0] | f3_hot[1] & f7_zero
                     | f3_hot[5] & (f7_zero | f7_alt));
  assign op_ok   = is_op & (f7_zero | f7_alt & (f3_hot[0] | f3_hot[5]));
  assign op32_ok = is_op_32 & (f7_zero & (f3_hot[0] | f3_hot[1] | f3_hot[5])
                 | f7_alt & (f3_hot[0] | f3_hot[5]));
  assign br_ok   = is_branch & ~(f3_hot[2] | f3_hot[3]);
  assign jalr_ok = is_jalr & f3_hot[0];

  assign imm_ok = op_imm_ok | op_imm32_ok;
  assign reg_ok = op_ok | op32_ok;
  assign alu_ok = imm_ok | reg_ok;

  // loads, stores, fence and system end up here too
  assign unsupported = ~(alu_ok | br_ok | jalr_ok | is_jal | is_lui | is_auipc);

  assign is_word_op  = is_op_imm_32 | is_op_32;
  assign op1_sel_pc  = is_auipc;
  assign op2_sel_imm = is_op_imm | is_op_imm_32 | is_lui | is_auipc | is_load | is_store;

  // register reads, unused ports read x0
  assign rs1_ena  = is_op_imm | is_op_imm_32 | is_op | is_op_32 | is_branch | is_jalr
                  | is_load | is_store | is_fence | is_system;
  assign rs2_ena  = is_op | is_op_32 | is_branch | is_store;
  assign rs1_addr = rs1_ena ? inst[19:15] : '0;
  assign rs2_addr = rs2_ena ? inst[24:20] : '0;

  assign rd_w_ena  = alu_ok | jalr_ok | is_jal | is_lui | is_auipc;
  assign rd_w_addr = rd_w_ena ? inst[11:7] : '0;

  assign imm = (is_lui | is_auipc) ? imm_u :
               is_store            ? imm_s : imm_i;

  // alu one-hot; immediate forms have no SUB so inst[30] is ignored there
  assign alu_op[rv_isa_pkg::ALU_ADD]  = (imm_ok | reg_ok & ~inst[30]) & f3_hot[0]
                                      | is_lui | is_auipc;
  assign alu_op[rv_isa_pkg::ALU_SUB]  = reg_ok & inst[30] & f3_hot[0];
  assign alu_op[rv_isa_pkg::ALU_SLT]  = alu_ok & f3_hot[2] | br_ok & (f3_hot[4] | f3_hot[5]);
  assign alu_op[rv_isa_pkg::ALU_SLTU] = alu_ok & f3_hot[3] | br_ok & (f3_hot[6] | f3_hot[7]);
  assign alu_op[rv_isa_pkg::ALU_XOR]  = alu_ok & f3_hot[4] | br_ok & (f3_hot[0] | f3_hot[1]);
  assign alu_op[rv_isa_pkg::ALU_OR]   = alu_ok & f3_hot[6];
  assign alu_op[rv_isa_pkg::ALU_AND]  = alu_ok & f3_hot[7];
  assign alu_op[rv_isa_pkg::ALU_SLL]  = alu_ok & f3_hot[1];
  assign alu_op[rv_isa_pkg::ALU_SRL]  = alu_ok & f3_hot[5] & ~inst[30];
  assign alu_op[rv_isa_pkg::ALU_SRA]  = alu_ok & f3_hot[5] & inst[30];

  assign bj_op[rv_isa_pkg::BJ_BEQ]  = br_ok & f3_hot[0];
  assign bj_op[rv_isa_pkg::BJ_BNE]  = br_ok & f3_hot[1];
  assign bj_op[rv_isa_pkg::BJ_BLT]  = br_ok & f3_hot[4];
  assign bj_op[rv_isa_pkg::BJ_BGE]  = br_ok & f3_hot[5];
  assign bj_op[rv_isa_pkg::BJ_BLTU] = br_ok & f3_hot[6];
  assign bj_op[rv_isa_pkg::BJ_BGEU] = br_ok & f3_hot[7];
  assign bj_op[rv_isa_pkg::BJ_JALR] = jalr_ok;
  assign bj_op[rv_isa_pkg::BJ_JAL]  = is_jal;

  // jalr target turned into a pc-relative offset, bit 0 cleared
  assign jalr_sum = r_data1 + imm_i;
  assign jalr_off = {jalr_sum[XLEN-1:1], 1'b0} - pc;

  assign jmp_off = ({XLEN{is_branch}} & imm_b)
                 | ({XLEN{is_jal}}    & imm_j)
                 | ({XLEN{is_jalr}}   & jalr_off);

endmodule

// File: hdl/regfile.sv
`timescale 1ns/100ps

module regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_isa_pkg::reg_addr_t rs1_addr,
  input  rv_isa_pkg::reg_addr_t rs2_addr,
  output rv_isa_pkg::reg_t      r_data1,
  output rv_isa_pkg::reg_t      r_data2,
  input  logic                  wb_ena,
  input  rv_isa_pkg::reg_addr_t wb_addr,
  input  rv_isa_pkg::reg_t      wb_data
);

  localparam int NUM_REGS = 2 ** rv_isa_pkg::REG_ADDR_W;

  // x1..x31, x0 has no storage
  rv_isa_pkg::reg_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_ena && (wb_addr != '0)) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // combinational reads, x0 is hardwired
  assign r_data1 = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign r_data2 = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: hdl/exe_stage.sv
`timescale 1ns/100ps

module exe_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  q_valid,
  output logic                  q_pop,
  input  rv_isa_pkg::reg_t      pc,
  input  rv_isa_pkg::reg_t      r_data1,
  input  rv_isa_pkg::reg_t      r_data2,
  input  logic                  rd_w_ena,
  input  rv_isa_pkg::reg_addr_t rd_w_addr,
  input  rv_isa_pkg::alu_op_t   alu_op,
  input  rv_isa_pkg::bj_t       bj_op,
  input  logic                  is_word_op,
  input  logic                  op1_sel_pc,
  input  logic                  op2_sel_imm,
  input  rv_isa_pkg::reg_t      imm,
  input  rv_isa_pkg::reg_t      jmp_off,
  input  logic                  unsupported,
  output logic                  wb_ena,
  output rv_isa_pkg::reg_addr_t wb_addr,
  output rv_isa_pkg::reg_t      wb_data,
  output logic                  retire_valid,
  output rv_isa_pkg::reg_t      retire_pc,
  output rv_isa_pkg::reg_addr_t retire_rd,
  output logic                  retire_we,
  output rv_isa_pkg::reg_t      retire_wdata,
  output rv_isa_pkg::reg_t      retire_next_pc,
  output logic                  retire_unsupported
);

  localparam int XLEN = rv_isa_pkg::XLEN;

  rv_isa_pkg::reg_t op1, op2;
  rv_isa_pkg::reg_t sum, diff, sll_res, srl_res, sra_res;
  rv_isa_pkg::reg_t sra_d;
  rv_isa_pkg::reg_t alu_res, result, pc_plus4, next_pc;
  logic [5:0]       shamt;
  logic signed [31:0] sra_w;
  logic             lt_s, lt_u;
  logic             jump, taken;

  // execute never stalls
  assign q_pop = q_valid;

  // lui gets a zero op1 since decode points rs1 at x0
  assign op1 = op1_sel_pc ? pc : r_data1;
  assign op2 = op2_sel_imm ? imm : r_data2;

  // word forms shift by 5 bits only
  assign shamt = is_word_op ? {1'b0, op2[4:0]} : op2[5:0];

  assign sum     = op1 + op2;
  assign diff    = op1 - op2;
  assign lt_s    = $signed(op1) < $signed(op2);
  assign lt_u    = op1 < op2;
  assign sll_res = op1 << shamt;
  assign sra_w   = $signed(op1[31:0]) >>> shamt[4:0];
  // full-width arithmetic shift kept apart so it stays signed
  assign sra_d   = $signed(op1) >>> shamt;
  assign srl_res = is_word_op ? {32'b0, op1[31:0] >> shamt[4:0]} : op1 >> shamt;
  assign sra_res = is_word_op ? {{32{sra_w[31]}}, sra_w} : sra_d;

  assign alu_res = ({XLEN{alu_op[rv_isa_pkg::ALU_ADD]}}  & sum)
                 | ({XLEN{alu_op[rv_isa_pkg::ALU_SUB]}}  & diff)
                 | ({XLEN{alu_op[rv_isa_pkg::ALU_SLT]}}  & {{(XLEN-1){1'b0}}, lt_s})
                 | ({XLEN{alu_op[rv_isa_pkg::ALU_SLTU]}} & {{(XLEN-1){1'b0}}, lt_u})
                 | ({XLEN{alu_op[rv_isa_pkg::ALU_XOR]}}  & (op1 ^ op2))
                 | ({XLEN{alu_op[rv_isa_pkg::ALU_OR]}}   & (op1 | op2))
                 | ({XLEN{alu_op[rv_isa_pkg::ALU_AND]}}  & (op1 & op2))
                 | ({XLEN{alu_op[rv_isa_pkg::ALU_SLL]}}  & sll_res)
                 | ({XLEN{alu_op[rv_isa_pkg::ALU_SRL]}}  & srl_res)
                 | ({XLEN{alu_op[rv_isa_pkg::ALU_SRA]}}  & sra_res);

  // word results sign-extend bit 31
  assign result = is_word_op ? {{32{alu_res[31]}}, alu_res[31:0]} : alu_res;

  // branch compare comes out of the alu: xor for eq/ne, slt(u) for the rest
  assign jump  = bj_op[rv_isa_pkg::BJ_JAL] | bj_op[rv_isa_pkg::BJ_JALR];
  assign taken = bj_op[rv_isa_pkg::BJ_BEQ] & (alu_res == '0)
               | bj_op[rv_isa_pkg::BJ_BNE] & (alu_res != '0)
               | (bj_op[rv_isa_pkg::BJ_BLT] | bj_op[rv_isa_pkg::BJ_BLTU]) & alu_res[0]
               | (bj_op[rv_isa_pkg::BJ_BGE] | bj_op[rv_isa_pkg::BJ_BGEU]) & ~alu_res[0]
               | jump;

  assign pc_plus4 = pc + 64'd4;
  assign next_pc  = taken ? pc + jmp_off : pc_plus4;

  // write-back lands on the same edge as the retire registers
  assign wb_ena  = q_valid & rd_w_ena;
  assign wb_addr = rd_w_addr;
  assign wb_data = jump ? pc_plus4 : result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
      retire_we    <= 1'b0;
    end else begin
      retire_valid <= q_valid;
      retire_we    <= wb_ena;
    end
  end

  always_ff @(posedge clk) begin
    if (q_valid) begin
      retire_pc          <= pc;
      retire_rd          <= rd_w_addr;
      retire_wdata       <= rd_w_ena ? wb_data : '0;
      retire_next_pc     <= next_pc;
      retire_unsupported <= unsupported;
    end
  end

endmodule

// File: hdl/rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  rv_isa_pkg::inst_t     in_inst,
  input  rv_isa_pkg::reg_t      in_pc,
  output logic                  in_credit,
  output logic                  retire_valid,
  output rv_isa_pkg::reg_t      retire_pc,
  output rv_isa_pkg::reg_addr_t retire_rd,
  output logic                  retire_we,
  output rv_isa_pkg::reg_t      retire_wdata,
  output rv_isa_pkg::reg_t      retire_next_pc,
  output logic                  retire_unsupported
);

  // queue head
  logic                  q_valid;
  logic                  q_pop;
  rv_isa_pkg::inst_t     q_inst;
  rv_isa_pkg::reg_t      q_pc;

  // register file ports
  rv_isa_pkg::reg_addr_t rs1_addr, rs2_addr;
  rv_isa_pkg::reg_t      r_data1, r_data2;
  logic                  wb_ena;
  rv_isa_pkg::reg_addr_t wb_addr;
  rv_isa_pkg::reg_t      wb_data;

  // decode results
  logic                  rd_w_ena;
  rv_isa_pkg::reg_addr_t rd_w_addr;
  rv_isa_pkg::alu_op_t   alu_op;
  rv_isa_pkg::bj_t       bj_op;
  logic                  is_word_op;
  logic                  op1_sel_pc;
  logic                  op2_sel_imm;
  rv_isa_pkg::reg_t      imm;
  rv_isa_pkg::reg_t      jmp_off;
  logic                  unsupported;

  inst_queue u_inst_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_inst   (in_inst),
    .in_pc     (in_pc),
    .q_pop     (q_pop),
    .q_valid   (q_valid),
    .q_inst    (q_inst),
    .q_pc      (q_pc),
    .in_credit (in_credit)
  );

  id_stage u_id_stage (
    .inst        (q_inst),
    .pc          (q_pc),
    .r_data1     (r_data1),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rd_w_ena    (rd_w_ena),
    .rd_w_addr   (rd_w_addr),
    .alu_op      (alu_op),
    .bj_op       (bj_op),
    .is_word_op  (is_word_op),
    .op1_sel_pc  (op1_sel_pc),
    .op2_sel_imm (op2_sel_imm),
    .imm         (imm),
    .jmp_off     (jmp_off),
    .unsupported (unsupported)
  );

  regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .r_data1  (r_data1),
    .r_data2  (r_data2),
    .wb_ena   (wb_ena),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data)
  );

  exe_stage u_exe_stage (
    .clk                (clk),
    .rst_n              (rst_n),
    .q_valid            (q_valid),
    .q_pop              (q_pop),
    .pc                 (q_pc),
    .r_data1            (r_data1),
    .r_data2            (r_data2),
    .rd_w_ena           (rd_w_ena),
    .rd_w_addr          (rd_w_addr),
    .alu_op             (alu_op),
    .bj_op              (bj_op),
    .is_word_op         (is_word_op),
    .op1_sel_pc         (op1_sel_pc),
    .op2_sel_imm        (op2_sel_imm),
    .imm                (imm),
    .jmp_off            (jmp_off),
    .unsupported        (unsupported),
    .wb_ena             (wb_ena),
    .wb_addr            (wb_addr),
    .wb_data            (wb_data),
    .retire_valid       (retire_valid),
    .retire_pc          (retire_pc),
    .retire_rd          (retire_rd),
    .retire_we          (retire_we),
    .retire_wdata       (retire_wdata),
    .retire_next_pc     (retire_next_pc),
    .retire_unsupported (retire_unsupported)
  );

endmodule

// File: tests/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;

  // gaps are drawn from two lfsr bits
  localparam int MAX_GAP = 3;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  in_valid;
  rv_isa_pkg::inst_t     in_inst;
  rv_isa_pkg::reg_t      in_pc;
  logic                  in_credit;
  logic                  retire_valid;
  rv_isa_pkg::reg_t      retire_pc;
  rv_isa_pkg::reg_addr_t retire_rd;
  logic                  retire_we;
  rv_isa_pkg::reg_t      retire_wdata;
  rv_isa_pkg::reg_t      retire_next_pc;
  logic                  retire_unsupported;

  // expected program, one row per instruction
  string             t_name[$];
  rv_isa_pkg::inst_t t_inst[$];
  rv_isa_pkg::reg_t  t_pc[$];
  int                t_rd[$];
  bit                t_we[$];
  rv_isa_pkg::reg_t  t_wdata[$];
  rv_isa_pkg::reg_t  t_npc[$];
  bit                t_unsup[$];

  int          errors;
  int          sent;
  int          retired;
  int          credit_pulses;
  int          credits;
  int          cycles;
  int          cycle_limit;
  logic [15:0] lfsr;

  rv_core_top DUT (
    .clk                (clk),
    .rst_n              (rst_n),
    .in_valid           (in_valid),
    .in_inst            (in_inst),
    .in_pc              (in_pc),
    .in_credit          (in_credit),
    .retire_valid       (retire_valid),
    .retire_pc          (retire_pc),
    .retire_rd          (retire_rd),
    .retire_we          (retire_we),
    .retire_wdata       (retire_wdata),
    .retire_next_pc     (retire_next_pc),
    .retire_unsupported (retire_unsupported)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // instruction encoders
  function automatic rv_isa_pkg::inst_t enc_r(int f7, int rs2, int rs1, int f3, int rd,
                                               logic [6:0] opc);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic rv_isa_pkg::inst_t enc_i(int imm, int rs1, int f3, int rd,
                                               logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic rv_isa_pkg::inst_t enc_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], rv_isa_pkg::OPC_STORE};
  endfunction

  function automatic rv_isa_pkg::inst_t enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            rv_isa_pkg::OPC_BRANCH};
  endfunction

  function automatic rv_isa_pkg::inst_t enc_u(int imm, int rd, logic [6:0] opc);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic rv_isa_pkg::inst_t enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_isa_pkg::OPC_JAL};
  endfunction

  // fibonacci lfsr, x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // idle cycles before the next beat, one step per bit
  function automatic int draw_gap();
    int gap;
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_next(lfsr);
      gap = gap * 2 + int'(lfsr[0]);
    end
    return gap;
  endfunction

  task automatic check_value(string name, string field, logic [63:0] exp, logic [63:0] act);
    if (act !== exp) begin
      errors++;
      $display("** Error: %s %s expected %h actual %h", name, field, exp, act);
    end
  endtask

  // pc of each row follows from its position
  task automatic push_row(string name, rv_isa_pkg::inst_t inst, int rd, bit we,
                          rv_isa_pkg::reg_t wdata, rv_isa_pkg::reg_t npc, bit unsup);
    t_pc.push_back(64'h1000 + 64'(4 * t_pc.size()));
    t_name.push_back(name);
    t_inst.push_back(inst);
    t_rd.push_back(rd);
    t_we.push_back(we);
    t_wdata.push_back(wdata);
    t_npc.push_back(npc);
    t_unsup.push_back(unsup);
  endtask

  task automatic write_row(string name, rv_isa_pkg::inst_t inst, int rd,
                           rv_isa_pkg::reg_t wdata, rv_isa_pkg::reg_t npc);
    push_row(name, inst, rd, 1'b1, wdata, npc, 1'b0);
  endtask

  task automatic plain_row(string name, rv_isa_pkg::inst_t inst, rv_isa_pkg::reg_t npc,
                           bit unsup);
    push_row(name, inst, 0, 1'b0, 64'h0, npc, unsup);
  endtask

  // program from all-zero registers, x1 = 100 and x2 = -3 early on
  task automatic build_table();
    logic [6:0] op, op_w, opi, opi_w, lui, auipc, jalr, load;
    op    = rv_isa_pkg::OPC_OP;
    op_w  = rv_isa_pkg::OPC_OP_32;
    opi   = rv_isa_pkg::OPC_OP_IMM;
    opi_w = rv_isa_pkg::OPC_OP_IMM_32;
    lui   = rv_isa_pkg::OPC_LUI;
    auipc = rv_isa_pkg::OPC_AUIPC;
    jalr  = rv_isa_pkg::OPC_JALR;
    load  = rv_isa_pkg::OPC_LOAD;
    write_row("add_zero_regs", enc_r(0, 2, 1, 0, 5, op), 5, 64'h0, 64'h1004);
    write_row("addi_pos", enc_i(100, 0, 0, 1, opi), 1, 64'h64, 64'h1008);
    write_row("addi_neg", enc_i(-3, 0, 0, 2, opi), 2, 64'hffff_ffff_ffff_fffd, 64'h100c);
    write_row("add", enc_r(0, 2, 1, 0, 3, op), 3, 64'h61, 64'h1010);
    write_row("sub", enc_r(32, 1, 2, 0, 4, op), 4, 64'hffff_ffff_ffff_ff99, 64'h1014);
    write_row("xor", enc_r(0, 2, 1, 4, 6, op), 6, 64'hffff_ffff_ffff_ff99, 64'h1018);
    write_row("or", enc_r(0, 2, 1, 6, 7, op), 7, 64'hffff_ffff_ffff_fffd, 64'h101c);
    write_row("andi", enc_i('hf0, 2, 7, 8, opi), 8, 64'hf0, 64'h1020);
    write_row("slt", enc_r(0, 1, 2, 2, 9, op), 9, 64'h1, 64'h1024);
    write_row("sltu", enc_r(0, 1, 2, 3, 10, op), 10, 64'h0, 64'h1028);
    write_row("slli", enc_i(40, 1, 1, 11, opi), 11, 64'h0000_6400_0000_0000, 64'h102c);
    write_row("srai", enc_i('h401, 2, 5, 12, opi), 12, 64'hffff_ffff_ffff_fffe, 64'h1030);
    write_row("srli", enc_i(60, 2, 5, 13, opi), 13, 64'hf, 64'h1034);
    write_row("srl_reg", enc_r(0, 1, 11, 5, 14, op), 14, 64'h640, 64'h1038);
    write_row("lui", enc_u('h80000, 16, lui), 16, 64'hffff_ffff_8000_0000, 64'h103c);
    write_row("addw", enc_r(0, 1, 16, 0, 15, op_w), 15, 64'hffff_ffff_8000_0064, 64'h1040);
    write_row("subw", enc_r(32, 1, 16, 0, 17, op_w), 17, 64'h0000_0000_7fff_ff9c, 64'h1044);
    write_row("slliw", enc_i(25, 1, 1, 18, opi_w), 18, 64'hffff_ffff_c800_0000, 64'h1048);
    write_row("sraw", enc_r(32, 1, 16, 5, 19, op_w), 19, 64'hffff_ffff_f800_0000, 64'h104c);
    write_row("auipc", enc_u('h12345, 20, auipc), 20, 64'h1234_604c, 64'h1050);
    write_row("addi_x0", enc_i(5, 1, 0, 0, opi), 0, 64'h69, 64'h1054);
    write_row("read_x0", enc_r(0, 1, 0, 0, 21, op), 21, 64'h64, 64'h1058);
    plain_row("beq_taken", enc_b(16, 1, 1, 0), 64'h1068, 1'b0);
    plain_row("beq_not", enc_b(16, 2, 1, 0), 64'h1060, 1'b0);
    plain_row("bne_taken", enc_b(-8, 2, 1, 1), 64'h1058, 1'b0);
    plain_row("bne_not", enc_b(8, 21, 1, 1), 64'h1068, 1'b0);
    plain_row("blt_taken", enc_b(32, 1, 2, 4), 64'h1088, 1'b0);
    plain_row("blt_not", enc_b(32, 2, 1, 4), 64'h1070, 1'b0);
    plain_row("bge_taken", enc_b(-16, 2, 1, 5), 64'h1060, 1'b0);
    plain_row("bge_not", enc_b(12, 1, 2, 5), 64'h1078, 1'b0);
    plain_row("bltu_taken", enc_b(20, 2, 1, 6), 64'h108c, 1'b0);
    plain_row("bltu_not", enc_b(20, 1, 2, 6), 64'h1080, 1'b0);
    plain_row("bgeu_taken", enc_b(64, 1, 2, 7), 64'h10c0, 1'b0);
    plain_row("bgeu_not", enc_b(64, 2, 1, 7), 64'h1088, 1'b0);
    write_row("jal", enc_j('h100, 22), 22, 64'h108c, 64'h1188);
    write_row("jalr", enc_i(7, 1, 0, 23, jalr), 23, 64'h1090, 64'h6a);
    plain_row("load", enc_i(8, 1, 2, 24, load), 64'h1094, 1'b1);
    plain_row("store", enc_s(16, 2, 1, 3), 64'h1098, 1'b1);
    plain_row("fence", 32'h0ff0000f, 64'h109c, 1'b1);
    plain_row("ecall", 32'h00000073, 64'h10a0, 1'b1);
    write_row("load_no_write", enc_r(0, 0, 24, 0, 25, op), 25, 64'h0, 64'h10a4);
    write_row("and", enc_r(0, 12, 7, 7, 26, op), 26, 64'hffff_ffff_ffff_fffc, 64'h10a8);
    write_row("sltiu", enc_i(-1, 1, 3, 27, opi), 27, 64'h1, 64'h10ac);
    write_row("ori", enc_i('h7ff, 0, 6, 28, opi), 28, 64'h7ff, 64'h10b0);
  endtask

  task automatic check_row(int r);
    check_value(t_name[r], "pc", t_pc[r], retire_pc);
    check_value(t_name[r], "next_pc", t_npc[r], retire_next_pc);
    check_value(t_name[r], "we", 64'(t_we[r]), 64'(retire_we));
    check_value(t_name[r], "unsupported", 64'(t_unsup[r]), 64'(retire_unsupported));
    if (t_we[r]) begin
      check_value(t_name[r], "rd", 64'(t_rd[r]), 64'(retire_rd));
      check_value(t_name[r], "wdata", t_wdata[r], retire_wdata);
    end
  endtask

  // one falling edge, the beat ends and a returned credit is collected
  task automatic next_slot();
    @(negedge clk);
    in_valid = 1'b0;
    if (in_credit) begin
      credits++;
    end
    if (credits > core_pkg::IQ_DEPTH) begin
      errors++;
      $display("credit overflow: sender holds %0d credits for %0d queue entries",
               credits, core_pkg::IQ_DEPTH);
    end
  endtask

  task automatic run_sender();
    int gap;
    for (int i = 0; i < t_inst.size(); i++) begin
      gap = draw_gap();
      repeat (gap) begin
        next_slot();
      end
      next_slot();
      while (credits == 0) begin
        next_slot();
      end
      in_valid = 1'b1;
      in_inst  = t_inst[i];
      in_pc    = t_pc[i];
      credits--;
      sent++;
    end
    next_slot();
  endtask

  task automatic finish_run();
    $display("errors: %0d, retired %0d of %0d, credits returned %0d",
             errors, retired, t_inst.size(), credit_pulses);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // retire checker, outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      if (retire_valid || in_credit) begin
        errors++;
        $display("retire or credit pulse seen while reset is asserted");
      end
    end else begin
      if (in_credit) begin
        credit_pulses++;
        if (credit_pulses > sent) begin
          errors++;
          $display("credit returned with no instruction outstanding");
        end
      end
      if (retire_valid) begin
        if (retired >= sent) begin
          errors++;
          $display("retire seen with no instruction outstanding");
        end else begin
          check_row(retired);
        end
        retired++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      errors++;
      $display("timeout after %0d cycles: %0d of %0d instructions retired",
               cycles, retired, t_inst.size());
      finish_run();
    end
  end

  initial begin
    rst_n         = 1'b0;
    in_valid      = 1'b0;
    in_inst       = '0;
    in_pc         = '0;
    errors        = 0;
    sent          = 0;
    retired       = 0;
    credit_pulses = 0;
    credits       = core_pkg::IQ_DEPTH;
    cycles        = 0;
    lfsr          = 16'd27;
    build_table();
    cycle_limit = 16 + t_inst.size() * (MAX_GAP + 4) + 50;
    repeat (16) begin
      @(negedge clk);
    end
    rst_n = 1'b1;
    run_sender();
    while (retired < t_inst.size()) begin
      @(negedge clk);
    end
    // a few more cycles to catch stray retires or credits
    repeat (2) begin
      @(negedge clk);
    end
    if (credit_pulses != sent) begin
      errors++;
      $display("credit count mismatch: %0d pulses returned for %0d instructions sent",
               credit_pulses, sent);
    end
    finish_run();
  end

endmodule

// File: project.f
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/inst_queue.sv
hdl/id_stage.sv
hdl/regfile.sv
hdl/exe_stage.sv
hdl/rv_core_top.sv
tests/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timing
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core_top
FILELIST  ?= project.f
SIM       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
